//--- design/ahb_decoder.sv
`timescale 1ns/1ps

module ahb_decoder (
  input  logic                            clk,
  input  logic                            rst,
  input  logic [ahb_pkg::addr_width-1:0]  haddr,
  input  logic [1:0]                      htrans,
  input  logic                            hreadyout_sram,
  input  logic                            hreadyout_gpio,
  input  logic [ahb_pkg::data_width-1:0]  hrdata_sram,
  input  logic [ahb_pkg::data_width-1:0]  hrdata_gpio,
  output logic                            hsel_sram,
  output logic                            hsel_gpio,
  output logic                            hready,
  output logic [ahb_pkg::data_width-1:0]  hrdata
);

  localparam int aw        = ahb_pkg::addr_width;
  localparam int sram_bits = $clog2(soc_map_pkg::sram_size);
  localparam int gpio_bits = $clog2(soc_map_pkg::gpio_size);
  localparam int idx_w     = $clog2(soc_map_pkg::slave_count);

  logic [idx_w-1:0] slv_addr;
  logic [idx_w-1:0] slv_data;

  // Region match on the upper address bits
  assign hsel_sram = haddr[aw-1:sram_bits] == soc_map_pkg::sram_base[aw-1:sram_bits];
  assign hsel_gpio = haddr[aw-1:gpio_bits] == soc_map_pkg::gpio_base[aw-1:gpio_bits];

  always_comb begin
    if (hsel_sram) begin
      slv_addr = idx_w'(soc_map_pkg::slv_sram);
    end else if (hsel_gpio) begin
      slv_addr = idx_w'(soc_map_pkg::slv_gpio);
    end else begin
      slv_addr = idx_w'(soc_map_pkg::slv_none);
    end
  end

  // Idle cycles leave the default slave in the data phase
  always_ff @(posedge clk) begin
    if (!rst) begin
      slv_data <= idx_w'(soc_map_pkg::slv_none);
    end else if (hready) begin
      slv_data <= (htrans == ahb_pkg::htrans_nonseq) ? slv_addr
                                                     : idx_w'(soc_map_pkg::slv_none);
    end
  end

  always_comb begin
    case (slv_data)
      idx_w'(soc_map_pkg::slv_sram): begin
        hrdata = hrdata_sram;
        hready = hreadyout_sram;
      end
      idx_w'(soc_map_pkg::slv_gpio): begin
        hrdata = hrdata_gpio;
        hready = hreadyout_gpio;
      end
      // Default slave
      default: begin
        hrdata = '0;
        hready = 1'b1;
      end
    endcase
  end

endmodule

//--- design/ahb_gpio.sv
`timescale 1ns/1ps

module ahb_gpio (
  input  logic                                clk,
  input  logic                                rst,
  input  logic                                hsel,
  input  logic [ahb_pkg::addr_width-1:0]      haddr,
  input  logic [1:0]                          htrans,
  input  logic                                hwrite,
  input  logic [ahb_pkg::data_width-1:0]      hwdata,
  input  logic [3:0]                          hprot,
  input  logic                                hready,
  input  logic [soc_map_pkg::gpio_width-1:0]  gpio_in,
  output logic [ahb_pkg::data_width-1:0]      hrdata,
  output logic                                hreadyout,
  output logic [soc_map_pkg::gpio_width-1:0]  gpio_out
);

  localparam int dw       = ahb_pkg::data_width;
  localparam int gw       = soc_map_pkg::gpio_width;
  localparam int off_bits = $clog2(soc_map_pkg::gpio_size);

  logic          access;
  logic          wr_q;
  logic          in_sel_q;
  logic          fetch_q;
  logic [gw-1:0] in_meta;
  logic [gw-1:0] in_sync;

  assign access = hsel && (htrans == ahb_pkg::htrans_nonseq) && hready;

  always_ff @(posedge clk) begin
    if (!rst) begin
      wr_q <= 1'b0;
    end else if (hready) begin
      wr_q <= access && hwrite && (hprot[0] == ahb_pkg::hprot_data[0]);
    end
  end

  always_ff @(posedge clk) begin
    if (access) begin
      in_sel_q <= haddr[off_bits-1:0] == soc_map_pkg::gpio_in_offset[off_bits-1:0];
      fetch_q  <= hprot[0] == ahb_pkg::hprot_opcode[0];
    end
  end

  // Output register only, writes to the input offset are ignored
  always_ff @(posedge clk) begin
    if (!rst) begin
      gpio_out <= '0;
    end else if (wr_q && !in_sel_q) begin
      gpio_out <= hwdata[gw-1:0];
    end
  end

  // Two-flop synchronizer
  always_ff @(posedge clk) begin
    in_meta <= gpio_in;
    in_sync <= in_meta;
  end

  always_comb begin
    if (fetch_q) begin
      hrdata = '0;
    end else if (in_sel_q) begin
      hrdata = dw'(in_sync);
    end else begin
      hrdata = dw'(gpio_out);
    end
  end

  assign hreadyout = 1'b1;

endmodule

//--- design/ahb_master_bridge.sv
`timescale 1ns/1ps

module ahb_master_bridge (
  input  logic                            clk,
  input  logic                            rst,
  input  logic                            core_valid,
  input  logic                            core_instr,
  input  logic [ahb_pkg::addr_width-1:0]  core_addr,
  input  logic [ahb_pkg::data_width-1:0]  core_wdata,
  input  logic [3:0]                      core_wstrb,
  output logic [ahb_pkg::data_width-1:0]  core_rdata,
  output logic                            core_ready,
  output logic [ahb_pkg::addr_width-1:0]  haddr,
  output logic [1:0]                      htrans,
  output logic                            hwrite,
  output logic [ahb_pkg::data_width-1:0]  hwdata,
  output logic [3:0]                      hprot,
  output logic [2:0]                      hsize,
  output logic [2:0]                      hburst,
  input  logic [ahb_pkg::data_width-1:0]  hrdata,
  input  logic                            hready
);

  typedef enum logic [1:0] {
    st_idle,
    st_addr,
    st_data
  } state_t;

  state_t state;
  state_t state_nxt;

  logic [ahb_pkg::addr_width-1:0] haddr_q;
  logic [ahb_pkg::data_width-1:0] hwdata_q;
  logic                           hwrite_q;
  logic [3:0]                     hprot_q;

  always_comb begin
    state_nxt = state;
    case (state)
      st_idle: begin
        if (core_valid) begin
          state_nxt = st_addr;
        end
      end
      // Address phase is accepted only while the bus is ready
      st_addr: begin
        if (hready) begin
          state_nxt = st_data;
        end
      end
      st_data: begin
        if (hready) begin
          state_nxt = st_idle;
        end
      end
      default: state_nxt = st_idle;
    endcase
  end

  always_ff @(posedge clk) begin
    if (!rst) begin
      state <= st_idle;
    end else begin
      state <= state_nxt;
    end
  end

  // Request fields are taken once, when the request is accepted
  always_ff @(posedge clk) begin
    if (state == st_idle && core_valid) begin
      haddr_q  <= core_addr;
      hwdata_q <= core_wdata;
      hwrite_q <= |core_wstrb;
      hprot_q  <= core_instr ? ahb_pkg::hprot_opcode : ahb_pkg::hprot_data;
    end
  end

  // NONSEQ only in the address phase, IDLE through the data phase
  assign htrans = (state == st_addr) ? ahb_pkg::htrans_nonseq : ahb_pkg::htrans_idle;
  assign haddr  = haddr_q;
  assign hwrite = hwrite_q;
  assign hwdata = hwdata_q;
  assign hprot  = hprot_q;
  assign hsize  = ahb_pkg::hsize_word;
  assign hburst = ahb_pkg::hburst_single;

  assign core_ready = (state == st_data) && hready;
  assign core_rdata = core_ready ? hrdata : '0;

endmodule

//--- design/ahb_pkg.sv
package ahb_pkg;

  // Bus widths
  localparam int addr_width = 32;
  localparam int data_width = 32;

  // Transfer type
  localparam logic [1:0] htrans_idle   = 2'b00;
  localparam logic [1:0] htrans_nonseq = 2'b10;

  // Only word transfers and single bursts are issued
  localparam logic [2:0] hsize_word    = 3'b010;
  localparam logic [2:0] hburst_single = 3'b000;

  localparam logic       hresp_okay    = 1'b0;

  // Bit 0 tells data access from opcode fetch
  localparam logic [3:0] hprot_opcode  = 4'b0000;
  localparam logic [3:0] hprot_data    = 4'b0001;

endpackage

//--- design/ahb_sram.sv
`timescale 1ns/1ps

module ahb_sram (
  input  logic                            clk,
  input  logic                            rst,
  input  logic                            hsel,
  input  logic [ahb_pkg::addr_width-1:0]  haddr,
  input  logic [1:0]                      htrans,
  input  logic                            hwrite,
  input  logic [ahb_pkg::data_width-1:0]  hwdata,
  input  logic                            hready,
  output logic [ahb_pkg::data_width-1:0]  hrdata,
  output logic                            hreadyout
);

  localparam int depth = soc_map_pkg::sram_depth_words;
  localparam int idx_w = $clog2(depth);

  logic [ahb_pkg::data_width-1:0] mem [0:depth-1];

  logic             access;
  logic             rd_wait;
  logic             wr_pend;
  logic [idx_w-1:0] word_q;
  logic [ahb_pkg::data_width-1:0] rdata_q;

  assign access = hsel && (htrans == ahb_pkg::htrans_nonseq) && hready;

  // rd_wait marks the first data cycle of a read
  always_ff @(posedge clk) begin
    if (!rst) begin
      rd_wait <= 1'b0;
      wr_pend <= 1'b0;
    end else if (hready) begin
      rd_wait <= access && !hwrite;
      wr_pend <= access && hwrite;
    end else begin
      rd_wait <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (access) begin
      word_q <= haddr[idx_w+1:2];
    end
  end

  // Write lands at the end of its data phase
  always_ff @(posedge clk) begin
    if (wr_pend && hready) begin
      mem[word_q] <= hwdata;
    end
  end

  // Array read during the wait cycle, word presented in the next one
  always_ff @(posedge clk) begin
    if (rd_wait) begin
      rdata_q <= mem[word_q];
    end
  end

  assign hrdata    = rdata_q;
  assign hreadyout = !rd_wait;

endmodule

//--- design/ahb_subsys_top.sv
`timescale 1ns/1ps

module ahb_subsys_top (
  input  logic                                clk,
  input  logic                                rst,
  input  logic                                core_valid,
  input  logic                                core_instr,
  input  logic [ahb_pkg::addr_width-1:0]      core_addr,
  input  logic [ahb_pkg::data_width-1:0]      core_wdata,
  input  logic [3:0]                          core_wstrb,
  input  logic [soc_map_pkg::gpio_width-1:0]  gpio_in,
  output logic [ahb_pkg::data_width-1:0]      core_rdata,
  output logic                                core_ready,
  output logic [soc_map_pkg::gpio_width-1:0]  gpio_out
);

  logic [ahb_pkg::addr_width-1:0] haddr;
  logic [1:0]                     htrans;
  logic                           hwrite;
  logic [ahb_pkg::data_width-1:0] hwdata;
  logic [3:0]                     hprot;
  logic [ahb_pkg::data_width-1:0] hrdata;
  logic                           hready;
  logic                           hsel_sram;
  logic                           hsel_gpio;
  logic                           hreadyout_sram;
  logic                           hreadyout_gpio;
  logic [ahb_pkg::data_width-1:0] hrdata_sram;
  logic [ahb_pkg::data_width-1:0] hrdata_gpio;

  // hsize and hburst are fixed, no slave looks at them
  ahb_master_bridge bridge (
    .clk(clk), .rst(rst),
    .core_valid(core_valid), .core_instr(core_instr), .core_addr(core_addr),
    .core_wdata(core_wdata), .core_wstrb(core_wstrb),
    .core_rdata(core_rdata), .core_ready(core_ready),
    .haddr(haddr), .htrans(htrans), .hwrite(hwrite), .hwdata(hwdata),
    .hprot(hprot), .hsize(), .hburst(),
    .hrdata(hrdata), .hready(hready)
  );

  ahb_decoder decoder (
    .clk(clk), .rst(rst), .haddr(haddr), .htrans(htrans),
    .hreadyout_sram(hreadyout_sram), .hreadyout_gpio(hreadyout_gpio),
    .hrdata_sram(hrdata_sram), .hrdata_gpio(hrdata_gpio),
    .hsel_sram(hsel_sram), .hsel_gpio(hsel_gpio),
    .hready(hready), .hrdata(hrdata)
  );

  ahb_sram sram (
    .clk(clk), .rst(rst), .hsel(hsel_sram), .haddr(haddr), .htrans(htrans),
    .hwrite(hwrite), .hwdata(hwdata), .hready(hready),
    .hrdata(hrdata_sram), .hreadyout(hreadyout_sram)
  );

  ahb_gpio gpio (
    .clk(clk), .rst(rst), .hsel(hsel_gpio), .haddr(haddr), .htrans(htrans),
    .hwrite(hwrite), .hwdata(hwdata), .hprot(hprot), .hready(hready),
    .gpio_in(gpio_in), .hrdata(hrdata_gpio), .hreadyout(hreadyout_gpio),
    .gpio_out(gpio_out)
  );

endmodule

//--- design/soc_map_pkg.sv
package soc_map_pkg;

  // SRAM region, code and data
  localparam logic [ahb_pkg::addr_width-1:0] sram_base = 32'h0000_0000;
  localparam logic [ahb_pkg::addr_width-1:0] sram_size = 32'h0001_0000;
  localparam int sram_depth_words = 16384;

  // GPIO region with two word registers
  localparam logic [ahb_pkg::addr_width-1:0] gpio_base       = 32'h4000_0000;
  localparam logic [ahb_pkg::addr_width-1:0] gpio_size       = 32'h0000_0008;
  localparam logic [ahb_pkg::addr_width-1:0] gpio_out_offset = 32'h0000_0000;
  localparam logic [ahb_pkg::addr_width-1:0] gpio_in_offset  = 32'h0000_0004;
  localparam int gpio_width = 8;

  // Slave indexes, the last one is the default slave
  localparam int slave_count = 3;
  localparam int slv_sram    = 0;
  localparam int slv_gpio    = 1;
  localparam int slv_none    = 2;

endpackage

//--- files.f
design/ahb_pkg.sv
design/soc_map_pkg.sv
design/ahb_master_bridge.sv
design/ahb_decoder.sv
design/ahb_sram.sv
design/ahb_gpio.sv
design/ahb_subsys_top.sv
sim/ahb_bridge_assert.sv
sim/ahb_subsys_checker.sv
sim/ahb_subsys_tb.sv

//--- sim/ahb_bridge_assert.sv
`timescale 1ns/1ps

module ahb_bridge_assert (
  input logic       clk,
  input logic       rst,
  input logic [1:0] htrans,
  input logic [2:0] hsize,
  input logic       core_ready
);

  int fail_count = 0;

  // One address phase per transfer, IDLE after it
  nonseq_one_cycle: assert property (
    @(posedge clk) disable iff (!rst)
    htrans == ahb_pkg::htrans_nonseq |=> htrans == ahb_pkg::htrans_idle
  ) else begin
    fail_count++;
    $error("htrans held NONSEQ for more than one cycle");
  end

  ready_pulse: assert property (
    @(posedge clk) disable iff (!rst)
    core_ready |=> !core_ready
  ) else begin
    fail_count++;
    $error("core_ready high for more than one cycle");
  end

  word_size: assert property (
    @(posedge clk) disable iff (!rst)
    hsize == ahb_pkg::hsize_word
  ) else begin
    fail_count++;
    $error("hsize is not a word transfer");
  end

  idle_after_reset: assert property (
    @(posedge clk)
    !rst |=> htrans == ahb_pkg::htrans_idle
  ) else begin
    fail_count++;
    $error("htrans not IDLE after reset");
  end

endmodule

bind ahb_master_bridge ahb_bridge_assert bridge_chk (
  .clk(clk), .rst(rst), .htrans(htrans), .hsize(hsize), .core_ready(core_ready)
);

//--- sim/ahb_subsys_checker.sv
`timescale 1ns/1ps

module ahb_subsys_checker (
  input  logic                                clk,
  input  logic                                rst,
  input  logic                                core_valid,
  input  logic                                core_instr,
  input  logic [ahb_pkg::addr_width-1:0]      core_addr,
  input  logic [ahb_pkg::data_width-1:0]      core_wdata,
  input  logic [3:0]                          core_wstrb,
  input  logic [3:0]                          exp_lat,
  input  logic [soc_map_pkg::gpio_width-1:0]  gpio_in,
  input  logic [ahb_pkg::data_width-1:0]      core_rdata,
  input  logic                                core_ready,
  input  logic [soc_map_pkg::gpio_width-1:0]  gpio_out,
  output int                                  test_count,
  output int                                  error_count
);

  localparam int ready_limit = 8;

  // SRAM words exist in the model only once written
  logic [ahb_pkg::data_width-1:0]     sram_model [int];
  logic [soc_map_pkg::gpio_width-1:0] gpio_model = '0;
  logic                               busy = 1'b0;
  logic                               hung = 1'b0;
  logic                               in_reset = 1'b0;
  logic                               reset_bad = 1'b0;
  logic                               gpio_ok;
  int                                 cycles;
  logic [ahb_pkg::addr_width-1:0]     req_addr;
  logic [ahb_pkg::data_width-1:0]     req_wdata;
  logic                               req_write;
  logic                               req_instr;
  logic [3:0]                         req_lat;

  initial begin
    test_count = 0;
    error_count = 0;
  end

  function automatic logic in_sram(input logic [31:0] a);
    return (a - soc_map_pkg::sram_base) < soc_map_pkg::sram_size;
  endfunction

  function automatic logic in_gpio(input logic [31:0] a);
    return (a - soc_map_pkg::gpio_base) < soc_map_pkg::gpio_size;
  endfunction

  function automatic int word_of(input logic [31:0] a);
    return int'((a - soc_map_pkg::sram_base) >> 2);
  endfunction

  // Returns 0 when the result is not predictable (SRAM word never written)
  function automatic logic read_value(input logic [31:0] a, input logic instr,
                                      output logic [31:0] value);
    value = '0;
    if (in_sram(a)) begin
      if (!sram_model.exists(word_of(a))) return 1'b0;
      value = sram_model[word_of(a)];
    end else if (in_gpio(a) && !instr) begin
      if (a - soc_map_pkg::gpio_base == soc_map_pkg::gpio_in_offset) value = 32'(gpio_in);
      else value = 32'(gpio_model);
    end
    return 1'b1;
  endfunction

  task automatic finish_test();
    logic [31:0] exp;
    logic        known;
    string       msg;
    msg = "";
    if (cycles != int'(req_lat)) begin
      msg = {msg, $sformatf(" latency %0d, expected %0d;", cycles, req_lat)};
    end
    if (!gpio_ok) msg = {msg, " gpio_out differs from the model;"};
    if (req_write) begin
      if (in_sram(req_addr)) begin
        sram_model[word_of(req_addr)] = req_wdata;
      end else if (in_gpio(req_addr) && !req_instr &&
                   req_addr - soc_map_pkg::gpio_base == soc_map_pkg::gpio_out_offset) begin
        gpio_model = req_wdata[soc_map_pkg::gpio_width-1:0];
      end
    end else begin
      known = read_value(req_addr, req_instr, exp);
      if (known && core_rdata !== exp) begin
        msg = {msg, $sformatf(" read 0x%08h, expected 0x%08h;", core_rdata, exp)};
      end
    end
    test_count++;
    if (msg == "") begin
      $display("Pass t=%0t: test %0d at 0x%08h", $time, test_count, req_addr);
    end else begin
      error_count++;
      $display("Fail t=%0t: test %0d at 0x%08h:%s", $time, test_count, req_addr, msg);
    end
  endtask

  // Sampled mid-cycle, when the DUT outputs and the driven inputs are settled
  always @(negedge clk) begin
    if (!rst) begin
      in_reset = 1'b1;
      busy = 1'b0;
      if (core_ready !== 1'b0 || gpio_out !== '0) reset_bad = 1'b1;
    end else begin
      if (in_reset) begin
        in_reset = 1'b0;
        if (core_ready !== 1'b0 || gpio_out !== '0) reset_bad = 1'b1;
        test_count++;
        if (reset_bad) begin
          error_count++;
          $display("Fail t=%0t: core_ready or gpio_out active around reset", $time);
        end else begin
          $display("Pass t=%0t: test %0d reset state", $time, test_count);
        end
      end
      if (!hung) begin
        if (busy) begin
          cycles++;
          if (core_ready === 1'b1) begin
            finish_test();
            busy = 1'b0;
          end else if (cycles >= ready_limit) begin
            hung = 1'b1;
            test_count++;
            error_count++;
            $display("Test %0d: the DUT never answered the request to address 0x%08h",
                     test_count, req_addr);
          end
        end else if (core_ready === 1'b1) begin
          error_count++;
          $display("core_ready seen at %0t with no request pending", $time);
        end else if (core_valid === 1'b1) begin
          busy = 1'b1;
          cycles = 0;
          req_addr = core_addr;
          req_wdata = core_wdata;
          req_write = |core_wstrb;
          req_instr = core_instr;
          req_lat = exp_lat;
          gpio_ok = gpio_out === gpio_model;
        end
      end
    end
  end

endmodule

//--- sim/ahb_subsys_tb.sv
`timescale 1ns/1ps

module ahb_subsys_tb;

  typedef enum logic [1:0] {
    op_read,
    op_write,
    op_fetch
  } op_t;

  typedef struct {
    op_t         op;
    logic [31:0] addr;
    logic [31:0] wdata;
    logic [7:0]  gin;
    logic [3:0]  lat;
    string       label;
  } row_t;

  localparam int clk_period    = 4;
  localparam int reset_cycles  = 3;
  localparam int row_cycles    = 8;
  localparam int margin_cycles = 20;

  logic        clk;
  logic        rst;
  logic        core_valid;
  logic        core_instr;
  logic [31:0] core_addr;
  logic [31:0] core_wdata;
  logic [3:0]  core_wstrb;
  logic [7:0]  gpio_in;
  logic [31:0] core_rdata;
  logic        core_ready;
  logic [7:0]  gpio_out;
  logic [3:0]  exp_lat;
  int          test_count;
  int          error_count;
  int          assert_fails;
  int          row_idx;
  logic [31:0] lfsr_state;
  row_t        rows [$];

  ahb_subsys_top UUT (
    .clk(clk), .rst(rst), .core_valid(core_valid), .core_instr(core_instr),
    .core_addr(core_addr), .core_wdata(core_wdata), .core_wstrb(core_wstrb),
    .gpio_in(gpio_in), .core_rdata(core_rdata), .core_ready(core_ready),
    .gpio_out(gpio_out)
  );

  ahb_subsys_checker chk (
    .clk(clk), .rst(rst), .core_valid(core_valid), .core_instr(core_instr),
    .core_addr(core_addr), .core_wdata(core_wdata), .core_wstrb(core_wstrb),
    .exp_lat(exp_lat), .gpio_in(gpio_in), .core_rdata(core_rdata),
    .core_ready(core_ready), .gpio_out(gpio_out),
    .test_count(test_count), .error_count(error_count)
  );

  initial begin
    clk = 1'b0;
    forever #(clk_period / 2) clk = ~clk;
  end

  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    if (s[0]) return (s >> 1) ^ 32'h8020_0003;
    return s >> 1;
  endfunction

  // One LFSR step per data bit
  function automatic logic [31:0] random_word();
    logic [31:0] w;
    for (int i = 0; i < 32; i++) begin
      lfsr_state = lfsr_step(lfsr_state);
      w[i] = lfsr_state[0];
    end
    return w;
  endfunction

  task automatic add_row(input op_t op, input logic [31:0] addr, input logic [7:0] gin,
                         input logic [3:0] lat, input string label);
    row_t r;
    r.op = op;
    r.addr = addr;
    r.wdata = (op == op_write) ? random_word() : 32'h0;
    r.gin = gin;
    r.lat = lat;
    r.label = label;
    rows.push_back(r);
  endtask

  // Expected latency is 3 for SRAM reads and fetches, 2 for everything else
  task automatic build_table();
    add_row(op_write, 32'h0000_0010, 8'h00, 2, "sram write 0x10");
    add_row(op_write, 32'h0000_0014, 8'h00, 2, "sram write 0x14");
    add_row(op_read,  32'h0000_0010, 8'h00, 3, "sram read 0x10");
    add_row(op_fetch, 32'h0000_0014, 8'h00, 3, "sram fetch 0x14");
    add_row(op_write, 32'h0000_fffc, 8'h00, 2, "sram write top word");
    add_row(op_read,  32'h0000_fffc, 8'h00, 3, "sram read top word");
    add_row(op_write, 32'h0000_0010, 8'h00, 2, "sram overwrite 0x10");
    add_row(op_fetch, 32'h0000_0010, 8'h00, 3, "sram fetch 0x10");
    add_row(op_read,  32'h0000_0014, 8'h00, 3, "sram read 0x14");
    add_row(op_write, 32'h4000_0000, 8'h00, 2, "gpio out write");
    add_row(op_read,  32'h4000_0000, 8'h00, 2, "gpio out read");
    add_row(op_fetch, 32'h4000_0000, 8'h00, 2, "gpio fetch");
    add_row(op_read,  32'h4000_0004, 8'h5a, 2, "gpio in read");
    add_row(op_read,  32'h4000_0004, 8'hc3, 2, "gpio in read again");
    add_row(op_write, 32'h4000_0004, 8'hc3, 2, "gpio in write ignored");
    add_row(op_write, 32'h2000_0000, 8'h00, 2, "unmapped write");
    add_row(op_read,  32'h2000_0000, 8'h00, 2, "unmapped read");
    add_row(op_write, 32'h0001_0010, 8'h00, 2, "write above sram");
    add_row(op_write, 32'h4000_0008, 8'h00, 2, "write above gpio");
    add_row(op_read,  32'h0000_0010, 8'h00, 3, "sram 0x10 kept");
    add_row(op_read,  32'h4000_0000, 8'h00, 2, "gpio out kept");
  endtask

  // gpio_in settles three cycles before the request, which is held until core_ready
  task automatic run_row(input row_t r);
    gpio_in = r.gin;
    repeat (3) @(posedge clk);
    #1;
    core_valid = 1'b1;
    core_instr = (r.op == op_fetch);
    core_addr = r.addr;
    core_wdata = r.wdata;
    core_wstrb = (r.op == op_write) ? 4'hf : 4'h0;
    exp_lat = r.lat;
    do @(negedge clk); while (core_ready !== 1'b1);
    @(posedge clk);
    #1;
    core_valid = 1'b0;
    core_instr = 1'b0;
    core_wstrb = 4'h0;
  endtask

  task automatic stop_on_timeout(input int limit_ns);
    #(limit_ns);
    if (row_idx < rows.size()) begin
      $display("Timeout at %0t ns, no progress in row %0d (%s)", $time, row_idx,
               rows[row_idx].label);
    end else begin
      $display("Timeout at %0t ns, run did not finish after the last row", $time);
    end
    $display("Result: FAILED");
    $finish;
  endtask

  initial begin
    rst = 1'b0;
    core_valid = 1'b0;
    core_instr = 1'b0;
    core_addr = '0;
    core_wdata = '0;
    core_wstrb = '0;
    gpio_in = '0;
    exp_lat = '0;
    row_idx = 0;
    lfsr_state = 32'ha8c1_2a57;
    build_table();
    fork
      stop_on_timeout((rows.size() * row_cycles + reset_cycles + margin_cycles) * clk_period);
    join_none
    repeat (reset_cycles) @(posedge clk);
    #1;
    rst = 1'b1;
    for (row_idx = 0; row_idx < rows.size(); row_idx++) begin
      run_row(rows[row_idx]);
    end
    repeat (4) @(posedge clk);
    assert_fails = UUT.bridge.bridge_chk.fail_count;
    $display("Tests: %0d run, %0d failed, %0d assertion failures",
             test_count, error_count, assert_fails);
    if (error_count == 0 && assert_fails == 0 && test_count == rows.size() + 1) begin
      $display("Result: PASSED");
    end else begin
      $display("Result: FAILED");
    end
    $finish;
  end

endmodule
